// ==== source/uart_pkg.sv ====
package uart_pkg;

  // Serial bit period in system clocks
  localparam int CLKS_PER_BIT = 8;

  // 8N1 framing
  localparam int DATA_BITS = 8;

  // Start bit plus data bits plus stop bit
  localparam int FRAME_BITS = DATA_BITS + 2;

  // Offset from the start-bit edge to its middle
  localparam int HALF_BIT = CLKS_PER_BIT / 2;

  // Counter widths
  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int BIT_W = $clog2(DATA_BITS);
  localparam int FRAME_W = $clog2(FRAME_BITS);

endpackage

// ==== source/mem_pkg.sv ====
package mem_pkg;

  // Buffer index width
  localparam int ADDR_W = 4;

  // Number of buffer entries
  localparam int DEPTH = 1 << ADDR_W;

  // Pointers carry one extra wrap bit so that full and empty differ
  localparam int PTR_W = ADDR_W + 1;

  // Payload width of one buffer entry
  localparam int DATA_W = 8;

  typedef logic [DATA_W-1:0] t_byte;

endpackage

// ==== source/reset_sync.sv ====
module reset_sync (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_pll_lock,
  output logic o_rst_n
);

  logic       arst_n;
  logic [1:0] sync_q;

  // Either the external reset or a lost PLL lock resets the core
  assign arst_n = i_rst_n & i_pll_lock;

  // Asserts at once and releases on the second clock edge
  always_ff @(posedge i_clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign o_rst_n = sync_q[1];

  // Lock seen low on either of the last two edges keeps the core in reset
  a_lock_holds_reset: assert property (@(posedge i_clk)
    !$past(i_pll_lock) || !$past(i_pll_lock, 2) |-> !o_rst_n)
    else $error("internal reset released too early after PLL lock loss");

endmodule

// ==== source/uart_rx_writer.sv ====
module uart_rx_writer (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic                       i_rx,
  output logic                       o_wr_req,
  output logic [mem_pkg::ADDR_W-1:0] o_wr_addr,
  output mem_pkg::t_byte             o_wr_data,
  input  logic                       i_wr_gnt,
  input  logic [mem_pkg::PTR_W-1:0]  i_rd_ptr,
  output logic [mem_pkg::PTR_W-1:0]  o_wr_ptr,
  output logic                       o_overflow
);

  import uart_pkg::*;
  import mem_pkg::*;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP,
    RX_WRITE
  } t_rx_state;

  t_rx_state        state;
  logic             rx_meta;
  logic             rx_sync;
  logic [CNT_W-1:0] clk_cnt;
  logic [BIT_W-1:0] bit_idx;
  t_byte            shift_q;
  logic [PTR_W-1:0] wr_ptr;
  logic             full;
  logic             bit_end;

  // Same index with different wrap bits means every entry is unread
  assign full = (wr_ptr[ADDR_W] != i_rd_ptr[ADDR_W]) &&
                (wr_ptr[ADDR_W-1:0] == i_rd_ptr[ADDR_W-1:0]);

  assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

  // Input synchronizer idles at the mark level
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= i_rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state      <= RX_IDLE;
      clk_cnt    <= '0;
      bit_idx    <= '0;
      wr_ptr     <= '0;
      o_overflow <= 1'b0;
    end else begin
      o_overflow <= 1'b0;
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          if (!rx_sync) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (clk_cnt == CNT_W'(HALF_BIT - 1)) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            // Line high again at mid start bit is a glitch
            state   <= rx_sync ? RX_IDLE : RX_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
          if (bit_end) begin
            if (bit_idx == BIT_W'(DATA_BITS - 1)) begin
              state <= RX_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end
        RX_STOP: begin
          clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
          if (bit_end) begin
            // Byte is complete at mid stop bit and is dropped if there is no room
            if (full) begin
              o_overflow <= 1'b1;
              state      <= RX_IDLE;
            end else begin
              state <= RX_WRITE;
            end
          end
        end
        RX_WRITE: begin
          if (i_wr_gnt) begin
            wr_ptr <= wr_ptr + 1'b1;
            state  <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge i_clk) begin
    if (state == RX_DATA && bit_end) begin
      shift_q <= {rx_sync, shift_q[DATA_BITS-1:1]};
    end
  end

  assign o_wr_req  = (state == RX_WRITE);
  assign o_wr_addr = wr_ptr[ADDR_W-1:0];
  assign o_wr_data = shift_q;
  assign o_wr_ptr  = wr_ptr;

  a_no_req_when_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(o_wr_req) |-> !full)
    else $error("write request raised with a full buffer");

endmodule

// ==== source/uart_tx_reader.sv ====
module uart_tx_reader (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  output logic                       o_rd_req,
  output logic [mem_pkg::ADDR_W-1:0] o_rd_addr,
  input  logic                       i_rd_gnt,
  input  mem_pkg::t_byte             i_rd_data,
  input  logic [mem_pkg::PTR_W-1:0]  i_wr_ptr,
  output logic [mem_pkg::PTR_W-1:0]  o_rd_ptr,
  output logic                       o_tx,
  output logic [mem_pkg::PTR_W-1:0]  o_level
);

  import uart_pkg::*;
  import mem_pkg::*;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_FETCH,
    TX_WAIT,
    TX_SHIFT
  } t_tx_state;

  t_tx_state             state;
  logic [CNT_W-1:0]      clk_cnt;
  logic [FRAME_W-1:0]    bit_idx;
  logic [FRAME_BITS-1:0] shift_q;
  logic [PTR_W-1:0]      rd_ptr;
  logic [PTR_W-1:0]      level;
  logic                  bit_end;

  // Wrap bit makes the difference the true occupancy, 0 to DEPTH
  assign level   = i_wr_ptr - rd_ptr;
  assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state   <= TX_IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      rd_ptr  <= '0;
      // Line idles high
      shift_q <= '1;
    end else begin
      case (state)
        TX_IDLE: begin
          if (level != '0) begin
            state <= TX_FETCH;
          end
        end
        TX_FETCH: begin
          if (i_rd_gnt) begin
            state <= TX_WAIT;
          end
        end
        TX_WAIT: begin
          // Registered memory output is valid one cycle after the grant
          shift_q <= {1'b1, i_rd_data, 1'b0};
          clk_cnt <= '0;
          bit_idx <= '0;
          state   <= TX_SHIFT;
        end
        TX_SHIFT: begin
          clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
          if (bit_end) begin
            shift_q <= {1'b1, shift_q[FRAME_BITS-1:1]};
            if (bit_idx == FRAME_W'(FRAME_BITS - 1)) begin
              // Entry is freed only after its stop bit
              rd_ptr <= rd_ptr + 1'b1;
              state  <= TX_IDLE;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  assign o_rd_req  = (state == TX_FETCH);
  assign o_rd_addr = rd_ptr[ADDR_W-1:0];
  assign o_rd_ptr  = rd_ptr;
  assign o_tx      = shift_q[0];
  assign o_level   = level;

  a_no_req_when_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_rd_req |-> level != '0)
    else $error("read request raised with an empty buffer");

endmodule

// ==== source/mem_arbiter.sv ====
module mem_arbiter (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic                       i_wr_req,
  input  logic [mem_pkg::ADDR_W-1:0] i_wr_addr,
  input  mem_pkg::t_byte             i_wr_data,
  output logic                       o_wr_gnt,
  input  logic                       i_rd_req,
  input  logic [mem_pkg::ADDR_W-1:0] i_rd_addr,
  output logic                       o_rd_gnt,
  output logic                       o_ram_we,
  output logic [mem_pkg::ADDR_W-1:0] o_ram_addr,
  output mem_pkg::t_byte             o_ram_wdata
);

  logic wr_gnt_d;
  logic rd_gnt_d;

  // Requests stay high through the grant cycle, so mask a repeat grant
  assign wr_gnt_d = i_wr_req & ~o_wr_gnt;
  // Writer wins any tie
  assign rd_gnt_d = i_rd_req & ~o_rd_gnt & ~wr_gnt_d;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wr_gnt <= 1'b0;
      o_rd_gnt <= 1'b0;
    end else begin
      o_wr_gnt <= wr_gnt_d;
      o_rd_gnt <= rd_gnt_d;
    end
  end

  // Port belongs to the granted engine for exactly one cycle
  assign o_ram_we    = o_wr_gnt;
  assign o_ram_addr  = o_wr_gnt ? i_wr_addr : i_rd_addr;
  assign o_ram_wdata = i_wr_data;

  a_gnt_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_wr_gnt && o_rd_gnt))
    else $error("write and read grants in the same cycle");

  // Engines must hold the request level until the grant arrives
  a_wr_gnt_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_wr_gnt |-> $past(i_wr_req) && i_wr_req)
    else $error("write grant without a held request");

  a_rd_gnt_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_rd_gnt |-> $past(i_rd_req) && i_rd_req)
    else $error("read grant without a held request");

endmodule

// ==== source/shared_ram.sv ====
module shared_ram #(
  parameter type t_word = mem_pkg::t_byte
) (
  input  logic                       i_clk,
  input  logic                       i_we,
  input  logic [mem_pkg::ADDR_W-1:0] i_addr,
  input  t_word                      i_wdata,
  output t_word                      o_rdata
);

  import mem_pkg::*;

  t_word mem [DEPTH];

  // Single port that returns the old contents on a write cycle
  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_addr] <= i_wdata;
    end
    o_rdata <= mem[i_addr];
  end

endmodule

// ==== source/echo_top.sv ====
module echo_top (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  logic                      i_pll_lock,
  input  logic                      i_uart_rd,
  output logic                      o_uart_td,
  output logic                      o_overflow,
  output logic [mem_pkg::PTR_W-1:0] o_led
);

  import mem_pkg::*;

  logic              rst_n_sync;

  // Engine to arbiter
  logic              wr_req;
  logic [ADDR_W-1:0] wr_addr;
  t_byte             wr_data;
  logic              wr_gnt;
  logic              rd_req;
  logic [ADDR_W-1:0] rd_addr;
  logic              rd_gnt;

  // Arbiter to memory
  logic              ram_we;
  logic [ADDR_W-1:0] ram_addr;
  t_byte             ram_wdata;
  t_byte             ram_rdata;

  // Pointer exchange between the engines
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;

  reset_sync rst0 (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_pll_lock (i_pll_lock),
    .o_rst_n    (rst_n_sync)
  );

  uart_rx_writer rx0 (
    .i_clk      (i_clk),
    .i_rst_n    (rst_n_sync),
    .i_rx       (i_uart_rd),
    .o_wr_req   (wr_req),
    .o_wr_addr  (wr_addr),
    .o_wr_data  (wr_data),
    .i_wr_gnt   (wr_gnt),
    .i_rd_ptr   (rd_ptr),
    .o_wr_ptr   (wr_ptr),
    .o_overflow (o_overflow)
  );

  uart_tx_reader tx0 (
    .i_clk     (i_clk),
    .i_rst_n   (rst_n_sync),
    .o_rd_req  (rd_req),
    .o_rd_addr (rd_addr),
    .i_rd_gnt  (rd_gnt),
    .i_rd_data (ram_rdata),
    .i_wr_ptr  (wr_ptr),
    .o_rd_ptr  (rd_ptr),
    .o_tx      (o_uart_td),
    .o_level   (o_led)
  );

  mem_arbiter arb0 (
    .i_clk       (i_clk),
    .i_rst_n     (rst_n_sync),
    .i_wr_req    (wr_req),
    .i_wr_addr   (wr_addr),
    .i_wr_data   (wr_data),
    .o_wr_gnt    (wr_gnt),
    .i_rd_req    (rd_req),
    .i_rd_addr   (rd_addr),
    .o_rd_gnt    (rd_gnt),
    .o_ram_we    (ram_we),
    .o_ram_addr  (ram_addr),
    .o_ram_wdata (ram_wdata)
  );

  shared_ram #(
    .t_word (t_byte)
  ) ram0 (
    .i_clk   (i_clk),
    .i_we    (ram_we),
    .i_addr  (ram_addr),
    .i_wdata (ram_wdata),
    .o_rdata (ram_rdata)
  );

endmodule

// ==== tests/echo_tb.sv ====
module echo_tb;

  import uart_pkg::*;
  import mem_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int FRAME_CLKS = FRAME_BITS * CLKS_PER_BIT;
  // Frames sent by all tests plus the idle and settle waits rounded up
  localparam int TOTAL_FRAMES = 50;
  localparam int WATCHDOG_CLKS = TOTAL_FRAMES * FRAME_CLKS * 3;

  logic             clk;
  logic             rst_n;
  logic             pll_lock;
  logic             uart_rd;
  logic             uart_td;
  logic             overflow;
  logic [PTR_W-1:0] led;

  logic [31:0] rng_state;
  t_byte       exp_q[$];
  t_byte       got_q[$];
  int          err_cnt;
  int          check_cnt;
  int          test_cnt;
  int          test_fail_cnt;
  int          accepted_cnt;
  int          ref_drop_cnt;
  int          echo_cnt;
  int          overflow_cnt;
  int          drop_epoch;
  bit          mon_enable;

  echo_top dut (
    .i_clk      (clk),
    .i_rst_n    (rst_n),
    .i_pll_lock (pll_lock),
    .i_uart_rd  (uart_rd),
    .o_uart_td  (uart_td),
    .o_overflow (overflow),
    .o_led      (led)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic t_byte next_byte();
    rng_state = lcg_next(rng_state);
    return rng_state[31:24];
  endfunction

  // Reference buffer keeps a byte only while fewer than DEPTH wait for echo
  function automatic bit ref_receive(input t_byte b);
    if (exp_q.size() >= DEPTH) begin
      return 1'b0;
    end
    exp_q.push_back(b);
    return 1'b1;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    err_cnt++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  // One 8N1 frame sent LSB first with each bit held for CLKS_PER_BIT clocks
  task automatic send_byte(input t_byte b);
    logic [FRAME_BITS-1:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < FRAME_BITS; i++) begin
      @(negedge clk);
      uart_rd = frame[i];
      repeat (CLKS_PER_BIT - 1) @(negedge clk);
    end
    if (ref_receive(b)) begin
      accepted_cnt++;
    end else begin
      ref_drop_cnt++;
    end
  endtask

  task automatic send_random(input int n);
    for (int i = 0; i < n; i++) begin
      send_byte(next_byte());
    end
  endtask

  task automatic wait_echoes(input int target, input int frames);
    int waited;
    waited = 0;
    while (echo_cnt < target && waited < frames * FRAME_CLKS) begin
      @(negedge clk);
      waited++;
    end
    if (echo_cnt < target) begin
      report_error($sformatf("only %0d of %0d bytes echoed in time", echo_cnt, target));
    end
  endtask

  // Read pointer moves half a bit after the monitor sees the stop bit
  task automatic settle_line();
    repeat (CLKS_PER_BIT) @(negedge clk);
  endtask

  task automatic finish_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt == err_before) begin
      $display("test %0d %s: pass", test_cnt, name);
    end else begin
      test_fail_cnt++;
      $display("test %0d %s: FAIL with %0d errors", test_cnt, name, err_cnt - err_before);
    end
  endtask

  // Serial monitor samples o_uart_td at mid-bit
  always begin
    int    epoch;
    t_byte data;
    @(negedge clk);
    if (mon_enable && uart_td === 1'b0) begin
      epoch = drop_epoch;
      repeat (HALF_BIT - 1) @(negedge clk);
      if (uart_td !== 1'b0) begin
        if (epoch == drop_epoch) begin
          report_error("start bit on o_uart_td shorter than half a bit");
        end
      end else begin
        for (int i = 0; i < DATA_BITS; i++) begin
          repeat (CLKS_PER_BIT) @(negedge clk);
          data[i] = uart_td;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        // A frame cut by a lock loss is not an echo
        if (epoch == drop_epoch) begin
          if (uart_td !== 1'b1) begin
            report_error("stop bit missing on o_uart_td");
          end else begin
            got_q.push_back(data);
            echo_cnt++;
          end
        end
      end
    end
  end

  always @(negedge clk) begin
    t_byte got;
    if (got_q.size() != 0) begin
      got = got_q.pop_front();
      if (exp_q.size() == 0) begin
        report_error("echoed byte that was never accepted");
      end else begin
        check_value("o_uart_td", 32'(got), 32'(exp_q.pop_front()));
      end
    end
  end

  always @(negedge clk) begin
    if (overflow === 1'b1) begin
      overflow_cnt++;
    end
  end

  initial begin
    repeat (WATCHDOG_CLKS) @(posedge clk);
    $display("watchdog expired after %0d clocks, run stopped", WATCHDOG_CLKS);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    int    err_before;
    int    prev;
    int    waited;
    clk = 1'b0;
    rst_n = 1'b0;
    pll_lock = 1'b1;
    uart_rd = 1'b1;
    rng_state = 32'h9c474c9d;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk);
    mon_enable = 1'b1;

    err_before = err_cnt;
    check_value("o_uart_td", 32'(uart_td), 32'd1);
    check_value("o_led", 32'(led), 32'd0);
    check_value("o_overflow", 32'(overflow), 32'd0);
    repeat (3 * FRAME_CLKS) @(negedge clk);
    check_value("echo count", 32'(echo_cnt), 32'd0);
    finish_test("reset values and quiet line", err_before);

    err_before = err_cnt;
    send_random(1);
    wait_echoes(1, 3);
    repeat (2 * FRAME_CLKS) @(negedge clk);
    check_value("echo count", 32'(echo_cnt), 32'd1);
    check_value("o_led", 32'(led), 32'd0);
    finish_test("single byte echo", err_before);

    err_before = err_cnt;
    send_random(8);
    wait_echoes(9, 4);
    settle_line();
    check_value("pending reference bytes", 32'(exp_q.size()), 32'd0);
    check_value("o_led", 32'(led), 32'd0);
    finish_test("eight byte burst in order", err_before);

    err_before = err_cnt;
    send_random(24);
    wait_echoes(33, 6);
    settle_line();
    check_value("o_overflow pulses", 32'(overflow_cnt), 32'(ref_drop_cnt));
    check_value("accepted bytes", 32'(accepted_cnt), 32'd33);
    check_value("o_led", 32'(led), 32'd0);
    finish_test("long burst without overflow", err_before);

    // Lock loss while the transmitter still has a backlog
    err_before = err_cnt;
    send_random(4);
    drop_epoch++;
    pll_lock = 1'b0;
    repeat (2) @(negedge clk);
    check_value("o_uart_td", 32'(uart_td), 32'd1);
    check_value("o_led", 32'(led), 32'd0);
    check_value("o_overflow", 32'(overflow), 32'd0);
    exp_q.delete();
    accepted_cnt = 0;
    echo_cnt = 0;
    repeat (20) @(negedge clk);
    check_value("o_uart_td", 32'(uart_td), 32'd1);
    check_value("o_led", 32'(led), 32'd0);
    pll_lock = 1'b1;
    repeat (4) @(negedge clk);
    send_random(3);
    wait_echoes(3, 4);
    settle_line();
    check_value("o_led", 32'(led), 32'd0);
    finish_test("lock loss and recovery", err_before);

    // Level seen at each stop bit while the buffer drains
    err_before = err_cnt;
    send_random(5);
    repeat (HALF_BIT) @(negedge clk);
    while (echo_cnt < accepted_cnt) begin
      prev = echo_cnt;
      waited = 0;
      while (echo_cnt == prev && waited < 2 * FRAME_CLKS) begin
        @(negedge clk);
        waited++;
      end
      if (echo_cnt == prev) begin
        report_error("buffer stopped draining");
        break;
      end
      check_value("o_led", 32'(led), 32'(accepted_cnt - echo_cnt + 1));
    end
    settle_line();
    check_value("o_led", 32'(led), 32'd0);
    finish_test("occupancy on o_led", err_before);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_cnt, test_fail_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
source/uart_pkg.sv
source/mem_pkg.sv
source/reset_sync.sv
source/uart_rx_writer.sv
source/uart_tx_reader.sv
source/mem_arbiter.sv
source/shared_ram.sv
source/echo_top.sv
tests/echo_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the echo testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module echo_tb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vecho_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
exit 0
